/* verilog/octavo_pkg.sv */
// Octavo barrel processor shared definitions
// Widths, instruction field layout, mapped I/O addresses and opcodes
package octavo_pkg;

    parameter int WORD_WIDTH      = 16;
    parameter int ADDR_WIDTH      = 8;
    parameter int THREAD_COUNT    = 4;
    parameter int THREAD_ID_WIDTH = 2;
    parameter int IMEM_ADDR_WIDTH = 6;
    // Instruction words owned by each thread
    parameter int THREAD_SPAN     = 16;
    parameter int OPCODE_WIDTH    = 4;

    // Opcode, D, A, B from the top bits down
    parameter int INSTR_WIDTH = OPCODE_WIDTH + 3 * ADDR_WIDTH;
    parameter int OPCODE_LSB  = 3 * ADDR_WIDTH;
    parameter int D_LSB       = 2 * ADDR_WIDTH;
    parameter int A_LSB       = ADDR_WIDTH;
    parameter int B_LSB       = 0;

    parameter logic [7:0] A_IO_READ_ADDR = 8'hF0;
    parameter logic [7:0] B_IO_READ_ADDR = 8'hF0;
    parameter logic [7:0] IO_WRITE_ADDR  = 8'hF8;

    // Unlisted codes behave as no-ops
    typedef enum logic [OPCODE_WIDTH-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        PASS_A = 4'd5,
        JMP    = 4'd6,
        JZ     = 4'd7
    } opcode_t;

endpackage

/* verilog/thread_counter.sv */
// Round-robin thread selector
// Steps through the threads every cycle and marks which slots may issue
`timescale 1ns/1ps

module thread_counter import octavo_pkg::*; #(
    parameter int THREAD_COUNT = octavo_pkg::THREAD_COUNT
) (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       run,
    output logic [THREAD_ID_WIDTH-1:0] thread_id,
    output logic                       issue_valid
);

    logic last_slot;
    logic active;

    assign last_slot   = (thread_id == THREAD_ID_WIDTH'(THREAD_COUNT - 1));
    // Issue opens on thread 0 and closes as soon as run drops
    assign issue_valid = run && active;

    always_ff @(posedge clock) begin
        if (rst) begin
            thread_id <= '0;
            active    <= 1'b0;
        end else begin
            thread_id <= last_slot ? '0 : thread_id + 1'b1;
            if (!run) begin
                active <= 1'b0;
            end else if (last_slot) begin
                active <= 1'b1;
            end
        end
    end

    a_issue_starts_at_zero: assert property (@(posedge clock) disable iff (rst)
        $rose(issue_valid) |-> run && thread_id == '0)
        else $error("issue started while run low or off thread 0");

endmodule

/* verilog/pc_file.sv */
// Per-thread program counters
// Supplies the fetch address for the issuing thread and takes
// next-PC updates from writeback
`timescale 1ns/1ps

module pc_file import octavo_pkg::*; #(
    parameter int THREAD_COUNT = octavo_pkg::THREAD_COUNT
) (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [THREAD_ID_WIDTH-1:0] thread_id,
    input  logic                       issue_valid,
    input  logic [THREAD_ID_WIDTH-1:0] wb_thread_id,
    input  logic                       wb_valid,
    input  logic                       branch_taken,
    input  logic [IMEM_ADDR_WIDTH-1:0] branch_target,
    output logic [IMEM_ADDR_WIDTH-1:0] fetch_addr,
    output logic [THREAD_ID_WIDTH-1:0] fetch_thread_id,
    output logic                       fetch_valid
);

    logic [IMEM_ADDR_WIDTH-1:0] pc [THREAD_COUNT];

    assign fetch_addr      = pc[thread_id];
    assign fetch_thread_id = thread_id;
    assign fetch_valid     = issue_valid;

    // Writeback lands one cycle before the same thread fetches again
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc[t] <= IMEM_ADDR_WIDTH'(t * THREAD_SPAN);
            end
        end else if (wb_valid) begin
            if (branch_taken) begin
                pc[wb_thread_id] <= branch_target;
            end else begin
                pc[wb_thread_id] <= pc[wb_thread_id] + 1'b1;
            end
        end
    end

endmodule

/* verilog/instr_mem.sv */
// Shared instruction memory
// Registered fetch, plus an external port for loading programs
`timescale 1ns/1ps

module instr_mem import octavo_pkg::*; (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       imem_wren,
    input  logic [IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [INSTR_WIDTH-1:0]     imem_wdata,
    input  logic [IMEM_ADDR_WIDTH-1:0] fetch_addr,
    input  logic [THREAD_ID_WIDTH-1:0] fetch_thread_id,
    input  logic                       fetch_valid,
    output logic [INSTR_WIDTH-1:0]     instr,
    output logic [THREAD_ID_WIDTH-1:0] instr_thread_id,
    output logic                       instr_valid
);

    logic [INSTR_WIDTH-1:0] ram [2**IMEM_ADDR_WIDTH];

    always_ff @(posedge clock) begin
        if (imem_wren) begin
            ram[imem_addr] <= imem_wdata;
        end
        instr           <= ram[fetch_addr];
        instr_thread_id <= fetch_thread_id;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= fetch_valid;
        end
    end

    a_no_load_while_running: assert property (@(posedge clock) disable iff (rst)
        imem_wren |-> !fetch_valid && !instr_valid)
        else $error("instruction load during active fetch");

endmodule

/* verilog/operand_mem.sv */
// Operand memory with one mapped I/O read port
// A valid read of IO_READ_ADDR strobes io_rden and returns io_in
// in place of the RAM word
`timescale 1ns/1ps

module operand_mem #(
    parameter int                    WORD_WIDTH   = octavo_pkg::WORD_WIDTH,
    parameter int                    ADDR_WIDTH   = octavo_pkg::ADDR_WIDTH,
    parameter logic [ADDR_WIDTH-1:0] IO_READ_ADDR = '0
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    input  logic                  rd_valid,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [WORD_WIDTH-1:0] wr_data,
    input  logic [WORD_WIDTH-1:0] io_in,
    output logic                  io_rden,
    output logic [WORD_WIDTH-1:0] operand
);

    logic [WORD_WIDTH-1:0] ram [2**ADDR_WIDTH];

    // Strobe in the read cycle, io_in sampled at its end
    assign io_rden = rd_valid && (rd_addr == IO_READ_ADDR);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clock) begin
        if (io_rden) begin
            operand <= io_in;
        end else begin
            operand <= ram[rd_addr];
        end
    end

    // Writeback trails the operand read by two cycles
    a_write_follows_read: assert property (@(posedge clock) disable iff (rst)
        wr_en |-> $past(rd_valid, 2))
        else $error("operand write without a matching read");

endmodule

/* verilog/alu.sv */
// Execute and writeback stages
// Aligns the instruction with its operands, computes the result or branch,
// and registers the writeback to memory, I/O and the PC file
`timescale 1ns/1ps

module alu import octavo_pkg::*; #(
    parameter int WORD_WIDTH = octavo_pkg::WORD_WIDTH,
    parameter int ADDR_WIDTH = octavo_pkg::ADDR_WIDTH
) (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [INSTR_WIDTH-1:0]     instr,
    input  logic [THREAD_ID_WIDTH-1:0] instr_thread_id,
    input  logic                       instr_valid,
    input  logic [WORD_WIDTH-1:0]      a_operand,
    input  logic [WORD_WIDTH-1:0]      b_operand,
    output logic [THREAD_ID_WIDTH-1:0] wb_thread_id,
    output logic                       wb_valid,
    output logic                       branch_taken,
    output logic [IMEM_ADDR_WIDTH-1:0] branch_target,
    output logic                       mem_wr_en,
    output logic [ADDR_WIDTH-1:0]      wr_addr,
    output logic [WORD_WIDTH-1:0]      wr_data,
    output logic                       a_io_wren,
    output logic [WORD_WIDTH-1:0]      a_io_out
);

    opcode_t                    ex_opcode;
    logic [ADDR_WIDTH-1:0]      ex_d;
    logic [THREAD_ID_WIDTH-1:0] ex_thread_id;
    logic                       ex_valid;
    logic [WORD_WIDTH-1:0]      result;
    logic                       do_write;
    logic                       do_branch;

    // Fields wait one cycle for the registered operands
    always_ff @(posedge clock) begin
        ex_opcode    <= opcode_t'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
        ex_d         <= instr[D_LSB +: ADDR_WIDTH];
        ex_thread_id <= instr_thread_id;
    end

    always_comb begin
        case (ex_opcode)
            ADD:     result = a_operand + b_operand;
            SUB:     result = a_operand - b_operand;
            AND:     result = a_operand & b_operand;
            OR:      result = a_operand | b_operand;
            XOR:     result = a_operand ^ b_operand;
            default: result = a_operand;
        endcase
    end

    assign do_write  = ex_opcode inside {ADD, SUB, AND, OR, XOR, PASS_A};
    assign do_branch = (ex_opcode == JMP) || (ex_opcode == JZ && a_operand == '0);

    always_ff @(posedge clock) begin
        wb_thread_id  <= ex_thread_id;
        branch_target <= ex_d[IMEM_ADDR_WIDTH-1:0];
        wr_addr       <= ex_d;
        wr_data       <= result;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            wb_valid     <= 1'b0;
            branch_taken <= 1'b0;
            mem_wr_en    <= 1'b0;
            a_io_wren    <= 1'b0;
        end else begin
            ex_valid     <= instr_valid;
            wb_valid     <= ex_valid;
            branch_taken <= ex_valid && do_branch;
            mem_wr_en    <= ex_valid && do_write;
            a_io_wren    <= ex_valid && do_write && (ex_d == ADDR_WIDTH'(IO_WRITE_ADDR));
        end
    end

    // The I/O write port shares the writeback data path
    assign a_io_out = wr_data;

    a_io_write_is_mem_write: assert property (@(posedge clock) disable iff (rst)
        a_io_wren |-> mem_wr_en)
        else $error("I/O write without a memory write");

endmodule

/* verilog/octavo_core.sv */
// Octavo scalar barrel processor
// Four threads share one instruction memory and the A and B operand memories
`timescale 1ns/1ps

module octavo_core import octavo_pkg::*; #(
    parameter int THREAD_COUNT = octavo_pkg::THREAD_COUNT,
    parameter int WORD_WIDTH   = octavo_pkg::WORD_WIDTH,
    parameter int ADDR_WIDTH   = octavo_pkg::ADDR_WIDTH
) (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       run,
    input  logic                       imem_wren,
    input  logic [IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [INSTR_WIDTH-1:0]     imem_wdata,
    input  logic [WORD_WIDTH-1:0]      a_io_in,
    input  logic [WORD_WIDTH-1:0]      b_io_in,
    output logic                       a_io_rden,
    output logic                       b_io_rden,
    output logic                       a_io_wren,
    output logic [WORD_WIDTH-1:0]      a_io_out
);

    logic [THREAD_ID_WIDTH-1:0] thread_id;
    logic                       issue_valid;
    logic [IMEM_ADDR_WIDTH-1:0] fetch_addr;
    logic [THREAD_ID_WIDTH-1:0] fetch_thread_id;
    logic                       fetch_valid;
    logic [INSTR_WIDTH-1:0]     instr;
    logic [THREAD_ID_WIDTH-1:0] instr_thread_id;
    logic                       instr_valid;
    logic [WORD_WIDTH-1:0]      a_operand;
    logic [WORD_WIDTH-1:0]      b_operand;
    logic [THREAD_ID_WIDTH-1:0] wb_thread_id;
    logic                       wb_valid;
    logic                       branch_taken;
    logic [IMEM_ADDR_WIDTH-1:0] branch_target;
    logic                       mem_wr_en;
    logic [ADDR_WIDTH-1:0]      wr_addr;
    logic [WORD_WIDTH-1:0]      wr_data;

    thread_counter #(
        .THREAD_COUNT (THREAD_COUNT)
    ) i_thread_counter (
        .clock       (clock),
        .rst         (rst),
        .run         (run),
        .thread_id   (thread_id),
        .issue_valid (issue_valid)
    );

    pc_file #(
        .THREAD_COUNT (THREAD_COUNT)
    ) i_pc_file (
        .clock           (clock),
        .rst             (rst),
        .thread_id       (thread_id),
        .issue_valid     (issue_valid),
        .wb_thread_id    (wb_thread_id),
        .wb_valid        (wb_valid),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .fetch_addr      (fetch_addr),
        .fetch_thread_id (fetch_thread_id),
        .fetch_valid     (fetch_valid)
    );

    instr_mem i_instr_mem (
        .clock           (clock),
        .rst             (rst),
        .imem_wren       (imem_wren),
        .imem_addr       (imem_addr),
        .imem_wdata      (imem_wdata),
        .fetch_addr      (fetch_addr),
        .fetch_thread_id (fetch_thread_id),
        .fetch_valid     (fetch_valid),
        .instr           (instr),
        .instr_thread_id (instr_thread_id),
        .instr_valid     (instr_valid)
    );

    operand_mem #(
        .WORD_WIDTH   (WORD_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .IO_READ_ADDR (ADDR_WIDTH'(A_IO_READ_ADDR))
    ) i_a_mem (
        .clock    (clock),
        .rst      (rst),
        .rd_addr  (instr[A_LSB +: ADDR_WIDTH]),
        .rd_valid (instr_valid),
        .wr_en    (mem_wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .io_in    (a_io_in),
        .io_rden  (a_io_rden),
        .operand  (a_operand)
    );

    operand_mem #(
        .WORD_WIDTH   (WORD_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .IO_READ_ADDR (ADDR_WIDTH'(B_IO_READ_ADDR))
    ) i_b_mem (
        .clock    (clock),
        .rst      (rst),
        .rd_addr  (instr[B_LSB +: ADDR_WIDTH]),
        .rd_valid (instr_valid),
        .wr_en    (mem_wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .io_in    (b_io_in),
        .io_rden  (b_io_rden),
        .operand  (b_operand)
    );

    alu #(
        .WORD_WIDTH (WORD_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_alu (
        .clock           (clock),
        .rst             (rst),
        .instr           (instr),
        .instr_thread_id (instr_thread_id),
        .instr_valid     (instr_valid),
        .a_operand       (a_operand),
        .b_operand       (b_operand),
        .wb_thread_id    (wb_thread_id),
        .wb_valid        (wb_valid),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .mem_wr_en       (mem_wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .a_io_wren       (a_io_wren),
        .a_io_out        (a_io_out)
    );

endmodule

/* test/clock_gen.sv */
// Testbench clock source
// Free-running clock, low at time zero
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD = 10.0
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2.0) clock = ~clock;
        end
    end

endmodule

/* include/tb_program.svh */
// Test table for the barrel processor testbench
// Rows hold short per-thread programs, the I/O inputs and the rule of each expected write

localparam int ROW_COUNT   = 9;
localparam int PROG_WORDS  = 5;
localparam int WRITE_COUNT = 4;

// Expected value rules, the first five share the ALU opcode codes
localparam int R_ADD  = 0;
localparam int R_SUB  = 1;
localparam int R_AND  = 2;
localparam int R_OR   = 3;
localparam int R_XOR  = 4;
// Sum when a_io_in is zero, difference otherwise
localparam int R_ZSEL = 5;

logic [INSTR_WIDTH-1:0] prog [ROW_COUNT][THREAD_COUNT][PROG_WORDS];
int                     prog_len [ROW_COUNT][THREAD_COUNT];
logic                   rand_tab [ROW_COUNT];
logic [WORD_WIDTH-1:0]  a_in_tab [ROW_COUNT];
logic [WORD_WIDTH-1:0]  b_in_tab [ROW_COUNT];
int                     rule_tab [ROW_COUNT][WRITE_COUNT];

function automatic logic [INSTR_WIDTH-1:0] encode(opcode_t op, logic [7:0] d,
                                                  logic [7:0] a, logic [7:0] b);
    return {op, d, a, b};
endfunction

// Both operands from the I/O ports, result to the I/O write port
function automatic logic [INSTR_WIDTH-1:0] io_op(opcode_t op);
    return encode(op, IO_WRITE_ADDR, A_IO_READ_ADDR, B_IO_READ_ADDR);
endfunction

function automatic logic [INSTR_WIDTH-1:0] jump_to(int target);
    return encode(JMP, 8'(target), 8'd0, 8'd0);
endfunction

task automatic add_word(int row, int thread, logic [INSTR_WIDTH-1:0] word);
    prog[row][thread][prog_len[row][thread]] = word;
    prog_len[row][thread]++;
endtask

task automatic set_row(int row, logic rnd, logic [WORD_WIDTH-1:0] a,
                       logic [WORD_WIDTH-1:0] b, int r0, int r1, int r2, int r3);
    rand_tab[row]    = rnd;
    a_in_tab[row]    = a;
    b_in_tab[row]    = b;
    rule_tab[row][0] = r0;
    rule_tab[row][1] = r1;
    rule_tab[row][2] = r2;
    rule_tab[row][3] = r3;
endtask

task automatic fill_table();
    for (int r = 0; r < ROW_COUNT; r++) begin
        for (int t = 0; t < THREAD_COUNT; t++) begin
            prog_len[r][t] = 0;
        end
    end
    // Rows 0 to 4 run one ALU opcode each on random inputs
    for (int r = 0; r <= 4; r++) begin
        add_word(r, 0, io_op(opcode_t'(r)));
        add_word(r, 0, jump_to(0));
        set_row(r, 1'b1, '0, '0, r, r, r, r);
    end
    // Store the sum at address 5 and copy it out
    add_word(5, 0, encode(ADD, 8'd5, A_IO_READ_ADDR, B_IO_READ_ADDR));
    add_word(5, 0, encode(PASS_A, IO_WRITE_ADDR, 8'd5, 8'd0));
    add_word(5, 0, jump_to(0));
    set_row(5, 1'b1, '0, '0, R_ADD, R_ADD, R_ADD, R_ADD);
    // JZ to word 3 takes the sum path, fall through takes the difference
    for (int r = 6; r <= 7; r++) begin
        add_word(r, 0, encode(JZ, 8'd3, A_IO_READ_ADDR, 8'd0));
        add_word(r, 0, io_op(SUB));
        add_word(r, 0, jump_to(0));
        add_word(r, 0, io_op(ADD));
        add_word(r, 0, jump_to(0));
    end
    set_row(6, 1'b0, 16'h0000, 16'h1234, R_ZSEL, R_ZSEL, R_ZSEL, R_ZSEL);
    set_row(7, 1'b0, 16'h00c3, 16'h0042, R_ZSEL, R_ZSEL, R_ZSEL, R_ZSEL);
    // Thread 0 adds and thread 2 subtracts on the same inputs
    add_word(8, 0, io_op(ADD));
    add_word(8, 0, jump_to(0));
    add_word(8, 2, io_op(SUB));
    add_word(8, 2, jump_to(2 * THREAD_SPAN));
    set_row(8, 1'b1, '0, '0, R_ADD, R_SUB, R_ADD, R_SUB);
endtask

/* test/tb_octavo.sv */
// Testbench for the Octavo barrel processor
// Loads short thread programs from a table and checks the I/O port writes
`timescale 1ns/1ps

module tb_octavo import octavo_pkg::*; ();

    logic                       clock;
    logic                       rst;
    logic                       run;
    logic                       imem_wren;
    logic [IMEM_ADDR_WIDTH-1:0] imem_addr;
    logic [INSTR_WIDTH-1:0]     imem_wdata;
    logic [WORD_WIDTH-1:0]      a_io_in;
    logic [WORD_WIDTH-1:0]      b_io_in;
    logic                       a_io_rden;
    logic                       b_io_rden;
    logic                       a_io_wren;
    logic [WORD_WIDTH-1:0]      a_io_out;
    int                         error_count;
    int                         check_count;
    int                         cycle_count;
    logic [31:0]                lcg_state;

    `include "tb_program.svh"

    localparam int CYCLE_LIMIT = ROW_COUNT * 200;

    clock_gen #(.PERIOD(10.0)) i_clock_gen (.clock(clock));

    octavo_core #(
        .THREAD_COUNT (THREAD_COUNT),
        .WORD_WIDTH   (WORD_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) i_dut (
        .clock      (clock),
        .rst        (rst),
        .run        (run),
        .imem_wren  (imem_wren),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .a_io_in    (a_io_in),
        .b_io_in    (b_io_in),
        .a_io_rden  (a_io_rden),
        .b_io_rden  (b_io_rden),
        .a_io_wren  (a_io_wren),
        .a_io_out   (a_io_out)
    );

    // Inputs change and outputs are sampled 1 ns after each rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) next_cycle();
        rst = 1'b0;
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [WORD_WIDTH-1:0] expected_value(int rule,
                                                            logic [WORD_WIDTH-1:0] a,
                                                            logic [WORD_WIDTH-1:0] b);
        case (rule)
            R_ADD:   return a + b;
            R_SUB:   return a - b;
            R_AND:   return a & b;
            R_OR:    return a | b;
            R_XOR:   return a ^ b;
            R_ZSEL:  return (a == '0) ? a + b : a - b;
            default: return 'x;
        endcase
    endfunction

    task automatic check_low(string name, logic value);
        check_count++;
        if (value !== 1'b0) begin
            error_count++;
            $display("ERROR %0t %s expected 0 got %b", $time, name, value);
        end
    endtask

    task automatic check_idle(int cycles);
        repeat (cycles) begin
            next_cycle();
            check_low("a_io_wren", a_io_wren);
            check_low("a_io_rden", a_io_rden);
            check_low("b_io_rden", b_io_rden);
        end
    endtask

    // Unused words of every region jump back to the region start
    task automatic load_program(int row);
        int t;
        int i;
        for (int addr = 0; addr < 2**IMEM_ADDR_WIDTH; addr++) begin
            t = addr / THREAD_SPAN;
            i = addr % THREAD_SPAN;
            imem_wren = 1'b1;
            imem_addr = IMEM_ADDR_WIDTH'(addr);
            if (i < prog_len[row][t]) begin
                imem_wdata = prog[row][t][i];
            end else begin
                imem_wdata = jump_to(t * THREAD_SPAN);
            end
            next_cycle();
        end
        imem_wren = 1'b0;
    endtask

    task automatic run_row(int row);
        logic [31:0]           draw;
        logic [WORD_WIDTH-1:0] a;
        logic [WORD_WIDTH-1:0] b;
        logic [WORD_WIDTH-1:0] want;
        int                    writes;
        int                    late_writes;
        int                    active_threads;
        bit                    seen_a;
        bit                    seen_b;
        run = 1'b0;
        a = a_in_tab[row];
        b = b_in_tab[row];
        if (rand_tab[row]) begin
            draw = lcg_next();
            a = draw[31:16];
            draw = lcg_next();
            b = draw[31:16];
        end
        a_io_in = a;
        b_io_in = b;
        active_threads = 0;
        for (int t = 0; t < THREAD_COUNT; t++) begin
            if (prog_len[row][t] > 0) begin
                active_threads++;
            end
        end
        apply_reset();
        load_program(row);
        run = 1'b1;
        writes = 0;
        seen_a = 1'b0;
        seen_b = 1'b0;
        while (writes < WRITE_COUNT) begin
            next_cycle();
            if (a_io_wren) begin
                want = expected_value(rule_tab[row][writes], a, b);
                check_count++;
                if (a_io_out !== want) begin
                    error_count++;
                    $display("ERROR %0t a_io_out expected %h got %h", $time, want, a_io_out);
                end
                if (!seen_a || !seen_b) begin
                    error_count++;
                    $display("Row %0d write %0d came without both read strobes before it",
                             row, writes);
                end
                seen_a = 1'b0;
                seen_b = 1'b0;
                writes++;
            end
            // Strobes of this cycle belong to a later write
            if (a_io_rden) seen_a = 1'b1;
            if (b_io_rden) seen_b = 1'b1;
        end
        // In-flight work drains, then the write port goes quiet
        // A thread that kept issuing would write twice in this window
        run = 1'b0;
        late_writes = 0;
        repeat (16) begin
            next_cycle();
            if (a_io_wren) late_writes++;
        end
        check_count++;
        if (late_writes > active_threads) begin
            error_count++;
            $display("Row %0d had %0d writes after run fell, more than its %0d threads",
                     row, late_writes, active_threads);
        end
        repeat (8) begin
            next_cycle();
            check_low("a_io_wren", a_io_wren);
        end
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        run         = 1'b0;
        imem_wren   = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        a_io_in     = '0;
        b_io_in     = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        lcg_state   = 32'h905afed6;
        fill_table();
        apply_reset();
        check_idle(20);
        for (int row = 0; row < ROW_COUNT; row++) begin
            run_row(row);
        end
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
verilog/octavo_pkg.sv
verilog/thread_counter.sv
verilog/pc_file.sv
verilog/instr_mem.sv
verilog/operand_mem.sv
verilog/alu.sv
verilog/octavo_core.sv
test/clock_gen.sv
test/tb_octavo.sv
